// ==== decode_stage.f ====
+incdir+tests
hw/decode_pkg.sv
hw/decoded_if.sv
hw/instr_decoder.sv
hw/imm_gen.sv
hw/decode_register.sv
hw/decode_stage.sv
tests/tb_decode_stage.sv

// ==== run.sh ====
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_decode_stage \
    -f decode_stage.f --Mdir obj_dir -o sim_decode_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_decode_stage > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "test passed" sim.log; then
    exit 0
fi
exit 1

// ==== tests/tb_ref_model.svh ====
// --------------------
// reference decode and instruction builders
// included inside the testbench module, needs rand_bits
// op is left loose on illegal encodings
// --------------------

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
    fu_t             fu;
    fu_op_t          op;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [4:0]      rd;
    logic            use_pc;
    logic            use_imm;
    logic [63:0]     imm;
    logic            ctrl_flow;
    logic            ex_valid;
    cause_t          cause;
} entry_t;

// sign-extend the low w bits of v
function automatic logic [63:0] sext(logic [63:0] v, int w);
    logic signed [63:0] t;
    t = v << (64 - w);
    return t >>> (64 - w);
endfunction

function automatic fu_op_t alu_op(logic [2:0] f3);
    case (f3)
        3'd0:    return ADD;
        3'd1:    return SLL;
        3'd2:    return SLTS;
        3'd3:    return SLTU;
        3'd4:    return XORL;
        3'd5:    return SRL;
        3'd6:    return ORL;
        default: return ANDL;
    endcase
endfunction

function automatic entry_t ref_decode(logic [31:0] in, priv_lvl_t priv);
    entry_t     e;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       ill;
    logic       ecall;
    logic       ebreak;
    logic [63:0] i_imm;
    e      = '0;
    f3     = in[14:12];
    f7     = in[31:25];
    ill    = 1'b0;
    ecall  = 1'b0;
    ebreak = 1'b0;
    i_imm  = sext(64'(in[31:20]), 12);
    case (in[6:0])
        OPCODE_OP, OPCODE_OP32: begin
            e.fu  = ALU;
            e.rs1 = in[19:15];
            e.rs2 = in[24:20];
            e.rd  = in[11:7];
            if (in[6:0] == OPCODE_OP) begin
                if (f7 == 7'h00)
                    e.op = alu_op(f3);
                else if (f7 == 7'h20 && f3 == 3'd0)
                    e.op = SUB;
                else if (f7 == 7'h20 && f3 == 3'd5)
                    e.op = SRA;
                else
                    ill = 1'b1;
            end else begin
                case ({f7, f3})
                    {7'h00, 3'd0}: e.op = ADDW;
                    {7'h20, 3'd0}: e.op = SUBW;
                    {7'h00, 3'd1}: e.op = SLLW;
                    {7'h00, 3'd5}: e.op = SRLW;
                    {7'h20, 3'd5}: e.op = SRAW;
                    default:       ill = 1'b1;
                endcase
            end
        end
        OPCODE_OPIMM, OPCODE_OPIMM32: begin
            e.fu      = ALU;
            e.rs1     = in[19:15];
            e.rd      = in[11:7];
            e.use_imm = 1'b1;
            e.imm     = i_imm;
            if (in[6:0] == OPCODE_OPIMM) begin
                if (f3 == 3'd1)
                    ill = (in[31:26] != 6'h00);
                else if (f3 == 3'd5)
                    ill = (in[31:26] != 6'h00) && (in[31:26] != 6'h10);
                e.op = (f3 == 3'd5 && in[30]) ? SRA : alu_op(f3);
            end else begin
                case (f3)
                    3'd0: e.op = ADDW;
                    3'd1: begin
                        e.op = SLLW;
                        ill  = (f7 != 7'h00);
                    end
                    3'd5: begin
                        e.op = in[30] ? SRAW : SRLW;
                        ill  = (f7 != 7'h00) && (f7 != 7'h20);
                    end
                    default: ill = 1'b1;
                endcase
            end
        end
        OPCODE_LOAD: begin
            e.fu      = LOAD;
            e.rs1     = in[19:15];
            e.rd      = in[11:7];
            e.use_imm = 1'b1;
            e.imm     = i_imm;
            case (f3)
                3'd0: e.op = LB;
                3'd1: e.op = LH;
                3'd2: e.op = LW;
                3'd3: e.op = LD;
                3'd4: e.op = LBU;
                3'd5: e.op = LHU;
                3'd6: e.op = LWU;
                default: ill = 1'b1;
            endcase
        end
        OPCODE_STORE: begin
            e.fu      = STORE;
            e.rs1     = in[19:15];
            e.rs2     = in[24:20];
            e.use_imm = 1'b1;
            e.imm     = sext(64'({in[31:25], in[11:7]}), 12);
            case (f3)
                3'd0: e.op = SB;
                3'd1: e.op = SH;
                3'd2: e.op = SW;
                3'd3: e.op = SD;
                default: ill = 1'b1;
            endcase
        end
        OPCODE_BRANCH: begin
            e.fu        = CTRL_FLOW;
            e.rs1       = in[19:15];
            e.rs2       = in[24:20];
            e.use_imm   = 1'b1;
            e.imm       = sext(64'({in[31], in[7], in[30:25], in[11:8], 1'b0}), 13);
            e.ctrl_flow = 1'b1;
            case (f3)
                3'd0: e.op = EQ;
                3'd1: e.op = NE;
                3'd4: e.op = LTS;
                3'd5: e.op = GES;
                3'd6: e.op = LTU;
                3'd7: e.op = GEU;
                default: begin
                    e.ctrl_flow = 1'b0;
                    ill         = 1'b1;
                end
            endcase
        end
        OPCODE_JALR: begin
            e.fu        = CTRL_FLOW;
            e.op        = JALR;
            e.rs1       = in[19:15];
            e.rd        = in[11:7];
            e.use_imm   = 1'b1;
            e.imm       = i_imm;
            e.ctrl_flow = 1'b1;
        end
        OPCODE_JAL: begin
            e.fu        = CTRL_FLOW;
            e.rd        = in[11:7];
            e.use_imm   = 1'b1;
            e.imm       = sext(64'({in[31], in[19:12], in[20], in[30:21], 1'b0}), 21);
            e.ctrl_flow = 1'b1;
        end
        OPCODE_LUI, OPCODE_AUIPC: begin
            e.fu      = ALU;
            e.rd      = in[11:7];
            e.use_imm = 1'b1;
            e.imm     = sext(64'({in[31:12], 12'h000}), 32);
            e.use_pc  = (in[6:0] == OPCODE_AUIPC);
        end
        OPCODE_SYSTEM: begin
            if (f3 == 3'd0 && in[19:15] == 5'd0 && in[11:7] == 5'd0 && in[31:21] == 11'd0) begin
                ecall  = ~in[20];
                ebreak = in[20];
            end else begin
                ill = 1'b1;
            end
        end
        default: ill = 1'b1;
    endcase
    e.ex_valid = ill | ecall | ebreak;
    if (ill)
        e.cause = ILLEGAL_INSTR;
    else if (ecall)
        e.cause = (priv == PRIV_LVL_U) ? ENV_CALL_UMODE :
                  (priv == PRIV_LVL_S) ? ENV_CALL_SMODE : ENV_CALL_MMODE;
    else if (ebreak)
        e.cause = BREAKPOINT;
    return e;
endfunction

// random instruction for opcode slot sel, 12 and 13 are unknown opcodes
function automatic logic [31:0] build_instr(int sel);
    logic [31:0] in;
    logic [1:0]  pick;
    in   = rand_bits(32);
    pick = 2'(rand_bits(2));
    case (sel)
        0:  in[6:0] = OPCODE_OP;
        1:  in[6:0] = OPCODE_OP32;
        2:  in[6:0] = OPCODE_OPIMM;
        3:  in[6:0] = OPCODE_OPIMM32;
        4:  in[6:0] = OPCODE_LOAD;
        5:  in[6:0] = OPCODE_STORE;
        6:  in[6:0] = OPCODE_BRANCH;
        7:  in[6:0] = OPCODE_JAL;
        8:  in[6:0] = OPCODE_JALR;
        9:  in[6:0] = OPCODE_LUI;
        10: in[6:0] = OPCODE_AUIPC;
        11: in[6:0] = OPCODE_SYSTEM;
        12: in[6:0] = 7'b000_1111; // fence space, dropped
        default: in[6:0] = 7'b111_1111;
    endcase
    // bias funct7 and shift bits toward legal encodings
    if (sel <= 3 && pick != 2'd3) begin
        in[31:25] = (pick == 2'd1) ? 7'h20 : 7'h00;
        if (sel == 2)
            in[25] = rand_bits(1) == 32'd1; // rv64 shamt bit 5
    end
    if (sel == 11 && pick != 2'd3) begin
        in[19:7] = 13'd0;
        if (pick != 2'd2)
            in[31:20] = 12'(pick);
    end
    return in;
endfunction

`endif

// ==== tests/tb_decode_stage.sv ====
// --------------------
// testbench for the RV64I decode stage
// inputs are driven and outputs checked on the falling edge
// expected entries come from the reference decode in the header
// stops at the first mismatch
// --------------------

`timescale 1ns/1ps

module tb_decode_stage;
    import decode_pkg::*;

    localparam time         clk_period   = 8ns;
    localparam logic [31:0] lfsr_seed    = 32'ha231;
    localparam int          num_random   = 600;

    logic        clk_i;
    logic        arst_n_i;
    logic        valid_i;
    logic [63:0] pc_i;
    logic [31:0] instr_i;
    priv_lvl_t   priv_lvl_i;
    logic        valid_o;
    logic [63:0] pc_o;
    fu_t         fu_o;
    fu_op_t      op_o;
    logic [4:0]  rs1_o;
    logic [4:0]  rs2_o;
    logic [4:0]  rd_o;
    logic        use_pc_o;
    logic        use_imm_o;
    logic [63:0] imm_o;
    logic        ctrl_flow_o;
    logic        ex_valid_o;
    cause_t      ex_cause_o;
    logic [63:0] ex_tval_o;

    logic [31:0] lfsr_state;

    // fibonacci taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            r          = {r[30:0], fb};
        end
        return r;
    endfunction

`include "tb_ref_model.svh"

    // model of what the outputs should hold
    logic        exp_valid;
    entry_t      exp_entry;
    logic [63:0] exp_pc;
    logic [31:0] exp_instr;

    decode_stage dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(clk_period / 2) clk_i = ~clk_i;
    end

    // --------------------
    // checking
    // --------------------
    task automatic check_field(string name, logic [63:0] exp_v, logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            $display("error at %0d ns: %s expected %h, got %h", $time, name, exp_v, act_v);
            $display("test failed");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_outputs();
        check_field("valid_o", 64'(exp_valid), 64'(valid_o));
        check_field("pc_o", exp_pc, pc_o);
        check_field("fu_o", 64'(exp_entry.fu), 64'(fu_o));
        if (!(exp_entry.ex_valid && exp_entry.cause == ILLEGAL_INSTR))
            check_field("op_o", 64'(exp_entry.op), 64'(op_o)); // op undefined when illegal
        check_field("rs1_o", 64'(exp_entry.rs1), 64'(rs1_o));
        check_field("rs2_o", 64'(exp_entry.rs2), 64'(rs2_o));
        check_field("rd_o", 64'(exp_entry.rd), 64'(rd_o));
        check_field("use_pc_o", 64'(exp_entry.use_pc), 64'(use_pc_o));
        check_field("use_imm_o", 64'(exp_entry.use_imm), 64'(use_imm_o));
        check_field("imm_o", exp_entry.imm, imm_o);
        check_field("ctrl_flow_o", 64'(exp_entry.ctrl_flow), 64'(ctrl_flow_o));
        check_field("ex_valid_o", 64'(exp_entry.ex_valid), 64'(ex_valid_o));
        check_field("ex_cause_o", 64'(exp_entry.cause), 64'(ex_cause_o));
        check_field("ex_tval_o", {32'd0, exp_instr}, ex_tval_o);
    endtask

    // --------------------
    // stimulus
    // --------------------
    task automatic step(logic v, logic [31:0] instr, priv_lvl_t priv);
        @(negedge clk_i);
        check_outputs(); // result of the previous cycle
        valid_i    = v;
        instr_i    = instr;
        priv_lvl_i = priv;
        pc_i       = {rand_bits(32), rand_bits(32)} & ~64'h3;
        exp_valid  = v;
        if (v) begin
            exp_entry = ref_decode(instr, priv);
            exp_pc    = pc_i;
            exp_instr = instr;
        end
    endtask

    function automatic priv_lvl_t rand_priv();
        logic [31:0] p;
        p = rand_bits(2);
        if (p == 32'd0)
            return PRIV_LVL_U;
        else if (p == 32'd1)
            return PRIV_LVL_S;
        return PRIV_LVL_M; // reserved level 2 is never driven
    endfunction

    initial begin
        lfsr_state = lfsr_seed;
        arst_n_i   = 1'b0;
        valid_i    = 1'b0;
        pc_i       = '0;
        instr_i    = '0;
        priv_lvl_i = PRIV_LVL_M;
        exp_valid  = 1'b0;
        exp_entry  = '0;
        exp_pc     = '0;
        exp_instr  = '0;

        repeat (10) begin
            @(negedge clk_i);
            check_outputs();
        end
        arst_n_i = 1'b1;

        // idle cycles then one pulse and its strobe
        repeat (3) step(1'b0, rand_bits(32), PRIV_LVL_M);
        step(1'b1, build_instr(0), PRIV_LVL_M);
        step(1'b0, rand_bits(32), PRIV_LVL_M);
        repeat (2) step(1'b0, rand_bits(32), PRIV_LVL_U);

        // ECALL at each level then EBREAK
        step(1'b1, 32'h0000_0073, PRIV_LVL_U);
        step(1'b1, 32'h0000_0073, PRIV_LVL_S);
        step(1'b1, 32'h0000_0073, PRIV_LVL_M);
        step(1'b1, 32'h0010_0073, PRIV_LVL_U);

        for (int i = 0; i < num_random; i++) begin
            step(rand_bits(2) != 32'd0, build_instr(int'(rand_bits(4)) % 14), rand_priv());
        end
        step(1'b0, rand_bits(32), PRIV_LVL_M);
        step(1'b0, rand_bits(32), PRIV_LVL_M);

        $display("test passed");
        $finish;
    end

endmodule

// ==== hw/decode_stage.sv ====
// --------------------
// RV64I decode stage, decoder plus one output register
// latency one cycle, accepts every cycle
// consumer must take every valid_o, there is no stall
// --------------------

`timescale 1ns/1ps

module decode_stage (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                valid_i,
    input  logic [decode_pkg::xlen-1:0]         pc_i,
    input  logic [decode_pkg::instr_w-1:0]      instr_i,
    input  decode_pkg::priv_lvl_t               priv_lvl_i,
    output logic                                valid_o,
    output logic [decode_pkg::xlen-1:0]         pc_o,
    output decode_pkg::fu_t                     fu_o,
    output decode_pkg::fu_op_t                  op_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rs1_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rs2_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rd_o,
    output logic                                use_pc_o,
    output logic                                use_imm_o,
    output logic [decode_pkg::xlen-1:0]         imm_o,
    output logic                                ctrl_flow_o,
    output logic                                ex_valid_o,
    output decode_pkg::cause_t                  ex_cause_o,
    output logic [decode_pkg::xlen-1:0]         ex_tval_o
);

    decoded_if dec_if ();

    logic [decode_pkg::xlen-1:0] imm;     // combinational immediate
    logic                        use_imm;

    // --------------------
    // producer side
    // --------------------
    instr_decoder i_instr_decoder (
        .instr_i    (instr_i),
        .priv_lvl_i (priv_lvl_i),
        .dec        (dec_if.producer)
    );

    imm_gen i_imm_gen (
        .instr_i   (instr_i),
        .dec       (dec_if.imm),
        .imm_o     (imm),
        .use_imm_o (use_imm)
    );

    // --------------------
    // decode/issue register
    // --------------------
    decode_register i_decode_register (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .valid_i     (valid_i),
        .instr_i     (instr_i),
        .pc_i        (pc_i),
        .dec         (dec_if.sink),
        .imm_i       (imm),
        .use_imm_i   (use_imm),
        .valid_o     (valid_o),
        .pc_o        (pc_o),
        .fu_o        (fu_o),
        .op_o        (op_o),
        .rs1_o       (rs1_o),
        .rs2_o       (rs2_o),
        .rd_o        (rd_o),
        .use_pc_o    (use_pc_o),
        .use_imm_o   (use_imm_o),
        .imm_o       (imm_o),
        .ctrl_flow_o (ctrl_flow_o),
        .ex_valid_o  (ex_valid_o),
        .ex_cause_o  (ex_cause_o),
        .ex_tval_o   (ex_tval_o)
    );

endmodule

// ==== hw/decode_register.sv ====
// --------------------
// decode/issue pipeline register, one cycle
// valid_o follows valid_i every cycle, no back-pressure
// entry only loads when valid_i is high, holds otherwise
// ex_tval carries the instruction word zero-extended
// --------------------

`timescale 1ns/1ps

module decode_register (
    input  logic                                clk_i,
    input  logic                                arst_n_i,
    input  logic                                valid_i,
    input  logic [decode_pkg::instr_w-1:0]      instr_i,
    input  logic [decode_pkg::xlen-1:0]         pc_i,
    decoded_if.sink                             dec,
    input  logic [decode_pkg::xlen-1:0]         imm_i,
    input  logic                                use_imm_i,
    output logic                                valid_o,
    output logic [decode_pkg::xlen-1:0]         pc_o,
    output decode_pkg::fu_t                     fu_o,
    output decode_pkg::fu_op_t                  op_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rs1_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rs2_o,
    output logic [decode_pkg::reg_addr_w-1:0]   rd_o,
    output logic                                use_pc_o,
    output logic                                use_imm_o,
    output logic [decode_pkg::xlen-1:0]         imm_o,
    output logic                                ctrl_flow_o,
    output logic                                ex_valid_o,
    output decode_pkg::cause_t                  ex_cause_o,
    output logic [decode_pkg::xlen-1:0]         ex_tval_o
);
    import decode_pkg::*;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_o     <= 1'b0;
            pc_o        <= '0;
            fu_o        <= NONE;
            op_o        <= ADD;
            rs1_o       <= '0;
            rs2_o       <= '0;
            rd_o        <= '0;
            use_pc_o    <= 1'b0;
            use_imm_o   <= 1'b0;
            imm_o       <= '0;
            ctrl_flow_o <= 1'b0;
            ex_valid_o  <= 1'b0;
            ex_cause_o  <= cause_t'(6'd0);
            ex_tval_o   <= '0;
        end else begin
            valid_o <= valid_i; // one strobe per accepted item
            if (valid_i) begin
                pc_o        <= pc_i;
                fu_o        <= dec.fu;
                op_o        <= dec.op;
                rs1_o       <= dec.rs1;
                rs2_o       <= dec.rs2;
                rd_o        <= dec.rd;
                use_pc_o    <= dec.use_pc;
                use_imm_o   <= use_imm_i;
                imm_o       <= imm_i;
                ctrl_flow_o <= dec.ctrl_flow;
                ex_valid_o  <= dec.ex_valid;
                ex_cause_o  <= dec.ex_cause;
                ex_tval_o   <= {{(xlen-instr_w){1'b0}}, instr_i};
            end
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
// --------------------
// sign-extended immediate for the selected format
// all layouts extend from instr bit 31
// NOIMM gives zero with use_imm low
// --------------------

`timescale 1ns/1ps

module imm_gen (
    input  logic [decode_pkg::instr_w-1:0] instr_i,
    decoded_if.imm                         dec,
    output logic [decode_pkg::xlen-1:0]    imm_o,
    output logic                           use_imm_o
);
    import decode_pkg::*;

    logic [xlen-1:0] imm_i_type;
    logic [xlen-1:0] imm_s_type;
    logic [xlen-1:0] imm_sb_type;
    logic [xlen-1:0] imm_u_type;
    logic [xlen-1:0] imm_uj_type;

    assign imm_i_type  = {{(xlen-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type  = {{(xlen-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_sb_type = {{(xlen-13){instr_i[31]}}, instr_i[31], instr_i[7],
                          instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type  = {{(xlen-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_uj_type = {{(xlen-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                          instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        use_imm_o = 1'b1;
        case (dec.imm_sel)
            IIMM:    imm_o = imm_i_type;
            SIMM:    imm_o = imm_s_type;
            SBIMM:   imm_o = imm_sb_type;
            UIMM:    imm_o = imm_u_type;
            JIMM:    imm_o = imm_uj_type;
            default: begin
                imm_o     = '0;
                use_imm_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== hw/instr_decoder.sv ====
// --------------------
// combinational RV64I decoder
// anything outside the base set, ECALL and EBREAK is illegal
// exception priority is illegal, then ECALL, then EBREAK
// ex_cause reads zero while ex_valid is low
// --------------------

`timescale 1ns/1ps

module instr_decoder (
    input  logic [decode_pkg::instr_w-1:0] instr_i,
    input  decode_pkg::priv_lvl_t          priv_lvl_i,
    decoded_if.producer                    dec
);
    import decode_pkg::*;

    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [reg_addr_w-1:0] rs1_f;
    logic [reg_addr_w-1:0] rs2_f;
    logic [reg_addr_w-1:0] rd_f;
    logic                  illegal_instr;
    logic                  ecall;
    logic                  ebreak;

    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rs1_f  = instr_i[19:15];
    assign rs2_f  = instr_i[24:20];
    assign rd_f   = instr_i[11:7];

    always_comb begin : decode
        dec.fu        = NONE;
        dec.op        = ADD;
        dec.rs1       = '0;
        dec.rs2       = '0;
        dec.rd        = '0;
        dec.use_pc    = 1'b0;
        dec.imm_sel   = NOIMM;
        dec.ctrl_flow = 1'b0;
        illegal_instr = 1'b0;
        ecall         = 1'b0;
        ebreak        = 1'b0;

        case (opcode)
            // --------------------
            // alu
            // --------------------
            OPCODE_OP: begin
                dec.fu  = ALU;
                dec.rs1 = rs1_f;
                dec.rs2 = rs2_f;
                dec.rd  = rd_f;
                case ({funct7, funct3})
                    {7'b000_0000, 3'b000}: dec.op = ADD;
                    {7'b010_0000, 3'b000}: dec.op = SUB;
                    {7'b000_0000, 3'b010}: dec.op = SLTS;
                    {7'b000_0000, 3'b011}: dec.op = SLTU;
                    {7'b000_0000, 3'b100}: dec.op = XORL;
                    {7'b000_0000, 3'b110}: dec.op = ORL;
                    {7'b000_0000, 3'b111}: dec.op = ANDL;
                    {7'b000_0000, 3'b001}: dec.op = SLL;
                    {7'b000_0000, 3'b101}: dec.op = SRL;
                    {7'b010_0000, 3'b101}: dec.op = SRA;
                    default:               illegal_instr = 1'b1;
                endcase
            end

            OPCODE_OP32: begin
                dec.fu  = ALU;
                dec.rs1 = rs1_f;
                dec.rs2 = rs2_f;
                dec.rd  = rd_f;
                case ({funct7, funct3})
                    {7'b000_0000, 3'b000}: dec.op = ADDW;
                    {7'b010_0000, 3'b000}: dec.op = SUBW;
                    {7'b000_0000, 3'b001}: dec.op = SLLW;
                    {7'b000_0000, 3'b101}: dec.op = SRLW;
                    {7'b010_0000, 3'b101}: dec.op = SRAW;
                    default:               illegal_instr = 1'b1;
                endcase
            end

            OPCODE_OPIMM: begin
                dec.fu      = ALU;
                dec.imm_sel = IIMM;
                dec.rs1     = rs1_f;
                dec.rd      = rd_f;
                case (funct3)
                    3'b000: dec.op = ADD;
                    3'b010: dec.op = SLTS;
                    3'b011: dec.op = SLTU;
                    3'b100: dec.op = XORL;
                    3'b110: dec.op = ORL;
                    3'b111: dec.op = ANDL;
                    3'b001: begin
                        dec.op = SLL;
                        illegal_instr = (instr_i[31:26] != 6'b0); // 6-bit shamt on rv64
                    end
                    default: begin // 3'b101
                        if (instr_i[31:26] == 6'b00_0000)
                            dec.op = SRL;
                        else if (instr_i[31:26] == 6'b01_0000)
                            dec.op = SRA;
                        else
                            illegal_instr = 1'b1;
                    end
                endcase
            end

            OPCODE_OPIMM32: begin
                dec.fu      = ALU;
                dec.imm_sel = IIMM;
                dec.rs1     = rs1_f;
                dec.rd      = rd_f;
                case (funct3)
                    3'b000: dec.op = ADDW;
                    3'b001: begin
                        dec.op = SLLW;
                        illegal_instr = (funct7 != 7'b0);
                    end
                    3'b101: begin
                        if (funct7 == 7'b000_0000)
                            dec.op = SRLW;
                        else if (funct7 == 7'b010_0000)
                            dec.op = SRAW;
                        else
                            illegal_instr = 1'b1;
                    end
                    default: illegal_instr = 1'b1;
                endcase
            end

            // --------------------
            // memory
            // --------------------
            OPCODE_LOAD: begin
                dec.fu      = LOAD;
                dec.imm_sel = IIMM;
                dec.rs1     = rs1_f;
                dec.rd      = rd_f;
                case (funct3)
                    3'b000:  dec.op = LB;
                    3'b001:  dec.op = LH;
                    3'b010:  dec.op = LW;
                    3'b011:  dec.op = LD;
                    3'b100:  dec.op = LBU;
                    3'b101:  dec.op = LHU;
                    3'b110:  dec.op = LWU;
                    default: illegal_instr = 1'b1;
                endcase
            end

            OPCODE_STORE: begin
                dec.fu      = STORE;
                dec.imm_sel = SIMM;
                dec.rs1     = rs1_f;
                dec.rs2     = rs2_f;
                case (funct3)
                    3'b000:  dec.op = SB;
                    3'b001:  dec.op = SH;
                    3'b010:  dec.op = SW;
                    3'b011:  dec.op = SD;
                    default: illegal_instr = 1'b1;
                endcase
            end

            // --------------------
            // control flow
            // --------------------
            OPCODE_BRANCH: begin
                dec.fu        = CTRL_FLOW;
                dec.imm_sel   = SBIMM;
                dec.rs1       = rs1_f;
                dec.rs2       = rs2_f;
                dec.ctrl_flow = 1'b1;
                case (funct3)
                    3'b000: dec.op = EQ;
                    3'b001: dec.op = NE;
                    3'b100: dec.op = LTS;
                    3'b101: dec.op = GES;
                    3'b110: dec.op = LTU;
                    3'b111: dec.op = GEU;
                    default: begin // funct3 2 and 3 are reserved
                        dec.ctrl_flow = 1'b0;
                        illegal_instr = 1'b1;
                    end
                endcase
            end

            OPCODE_JALR: begin
                dec.fu        = CTRL_FLOW;
                dec.op        = JALR;
                dec.imm_sel   = IIMM;
                dec.rs1       = rs1_f;
                dec.rd        = rd_f;
                dec.ctrl_flow = 1'b1;
            end

            OPCODE_JAL: begin
                dec.fu        = CTRL_FLOW; // op stays ADD, target from pc + imm
                dec.imm_sel   = JIMM;
                dec.rd        = rd_f;
                dec.ctrl_flow = 1'b1;
            end

            OPCODE_AUIPC: begin
                dec.fu      = ALU;
                dec.imm_sel = UIMM;
                dec.use_pc  = 1'b1;
                dec.rd      = rd_f;
            end

            OPCODE_LUI: begin
                dec.fu      = ALU;
                dec.imm_sel = UIMM;
                dec.rd      = rd_f;
            end

            OPCODE_SYSTEM: begin
                // only ECALL and EBREAK survive here
                if (funct3 != 3'b000 || rs1_f != '0 || rd_f != '0)
                    illegal_instr = 1'b1;
                else if (instr_i[31:20] == 12'd0)
                    ecall = 1'b1;
                else if (instr_i[31:20] == 12'd1)
                    ebreak = 1'b1;
                else
                    illegal_instr = 1'b1;
            end

            default: illegal_instr = 1'b1;
        endcase
    end

    // --------------------
    // exception record
    // --------------------
    always_comb begin : exception
        dec.ex_valid = illegal_instr | ecall | ebreak;
        dec.ex_cause = cause_t'(6'd0);
        if (illegal_instr) begin
            dec.ex_cause = ILLEGAL_INSTR;
        end else if (ecall) begin
            case (priv_lvl_i)
                PRIV_LVL_U: dec.ex_cause = ENV_CALL_UMODE;
                PRIV_LVL_S: dec.ex_cause = ENV_CALL_SMODE;
                default:    dec.ex_cause = ENV_CALL_MMODE; // reserved level treated as M
            endcase
        end else if (ebreak) begin
            dec.ex_cause = BREAKPOINT;
        end
    end

endmodule

// ==== hw/decoded_if.sv ====
// --------------------
// decoded fields from the decoder to the immediate
// generator and the decode register
// purely combinational, no clock inside
// --------------------

`timescale 1ns/1ps

interface decoded_if;
    import decode_pkg::*;

    fu_t                   fu;
    fu_op_t                op;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [reg_addr_w-1:0] rd;
    logic                  use_pc;     // AUIPC adds the pc
    imm_sel_t              imm_sel;
    logic                  ctrl_flow;  // branch, JAL or JALR
    logic                  ex_valid;
    cause_t                ex_cause;

    modport producer (
        output fu, op, rs1, rs2, rd, use_pc, imm_sel, ctrl_flow, ex_valid, ex_cause
    );

    modport imm (
        input imm_sel
    );

    modport sink (
        input fu, op, rs1, rs2, rd, use_pc, ctrl_flow, ex_valid, ex_cause
    );

endinterface

// ==== hw/decode_pkg.sv ====
// --------------------
// shared definitions for the RV64I decode stage
// covers the base integer set plus ECALL and EBREAK only
// no CSR, fence or compressed encodings
// opcode enum values carry an OPCODE_ prefix
// --------------------

package decode_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int unsigned xlen       = 64;
    localparam int unsigned instr_w    = 32;
    localparam int unsigned reg_addr_w = 5;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPCODE_LOAD    = 7'b000_0011,
        OPCODE_OPIMM   = 7'b001_0011,
        OPCODE_AUIPC   = 7'b001_0111,
        OPCODE_OPIMM32 = 7'b001_1011,
        OPCODE_STORE   = 7'b010_0011,
        OPCODE_OP      = 7'b011_0011,
        OPCODE_LUI     = 7'b011_0111,
        OPCODE_OP32    = 7'b011_1011,
        OPCODE_BRANCH  = 7'b110_0011,
        OPCODE_JALR    = 7'b110_0111,
        OPCODE_JAL     = 7'b110_1111,
        OPCODE_SYSTEM  = 7'b111_0011
    } opcode_t;

    // functional unit the scoreboard dispatches to
    typedef enum logic [2:0] {
        NONE,
        ALU,
        LOAD,
        STORE,
        CTRL_FLOW
    } fu_t;

    // --------------------
    // operations
    // --------------------
    typedef enum logic [5:0] {
        // alu, ADD first so it encodes as zero
        ADD, SUB, SLTS, SLTU, XORL, ORL, ANDL, SLL, SRL, SRA,
        ADDW, SUBW, SLLW, SRLW, SRAW,
        // loads
        LB, LH, LW, LD, LBU, LHU, LWU,
        // stores
        SB, SH, SW, SD,
        // branches and jumps
        EQ, NE, LTS, GES, LTU, GEU, JALR
    } fu_op_t;

    // immediate layout chosen by the decoder
    typedef enum logic [2:0] {
        NOIMM,
        IIMM,
        SIMM,
        SBIMM,
        UIMM,
        JIMM
    } imm_sel_t;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'd0,
        PRIV_LVL_S = 2'd1,
        PRIV_LVL_M = 2'd3
    } priv_lvl_t;

    // mcause encodings, synchronous exceptions only
    typedef enum logic [5:0] {
        ILLEGAL_INSTR  = 6'd2,
        BREAKPOINT     = 6'd3,
        ENV_CALL_UMODE = 6'd8,
        ENV_CALL_SMODE = 6'd9,
        ENV_CALL_MMODE = 6'd11
    } cause_t;

endpackage
